// File: riscv_pkg.sv
// ==============================
// shared widths, opcodes and stage types for the three-stage RV32 core
// imported by every core module
// ==============================
`default_nettype none

package riscv_pkg;

    // data path and register index widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // ADDI x0,x0,0 used as the fetch bubble
    localparam logic [31:0] nop_inst = 32'h0000_0013;

    // major opcodes kept by this core
    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;

    // pipeline hold level, driven by ctrl
    typedef enum logic [1:0] {
        hold_none = 2'd0,
        // pc frozen, bubble into decode
        hold_pc   = 2'd1,
        // pc and if/id frozen, bubble into execute
        hold_id   = 2'd2
    } hold_e;

    // instruction formats
    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } r_t;

    typedef struct packed {
        logic [11:0]           imm12;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } i_t;

    typedef struct packed {
        logic                  imm12;
        logic [5:0]            imm10_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm4_1;
        logic                  imm11;
        logic [6:0]            opcode;
    } b_t;

    typedef struct packed {
        logic                  imm20;
        logic [9:0]            imm10_1;
        logic                  imm11;
        logic [7:0]            imm19_12;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } j_t;

    // one word, four readings; decode picks by opcode
    typedef union packed {
        r_t r;
        i_t i;
        b_t b;
        j_t j;
    } inst_u;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_xor = 3'd2,
        alu_mul = 3'd3,
        alu_beq = 3'd4,
        alu_bne = 3'd5,
        alu_jal = 3'd6
    } alu_op_e;

    // fetch to decode
    typedef struct packed {
        logic [31:0]     inst;
        logic [xlen-1:0] pc;
    } if_id_t;

    // decode to execute, valid low means bubble
    typedef struct packed {
        logic                  valid;
        alu_op_e               alu_op;
        logic [reg_addr_w-1:0] rd;
        logic                  we;
        logic [xlen-1:0]       op_a;
        logic [xlen-1:0]       op_b;
        logic [xlen-1:0]       rs2_val;
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       imm;
    } id_ex_t;

endpackage

`default_nettype wire

// File: ctrl.sv
// ==============================
// pipeline control, turns jump and stall requests into one hold level
// ==============================
`default_nettype none

module ctrl (
    // from execute
    input  logic                       jump_flag_i,
    input  logic [riscv_pkg::xlen-1:0] jump_addr_i,
    input  logic                       hold_flag_ex_i,
    // instruction memory wait
    input  logic                       hold_flag_mems_i,
    output riscv_pkg::hold_e           hold_flag_o,
    // to fetch and decode
    output logic                       jump_flag_o,
    output logic [riscv_pkg::xlen-1:0] jump_addr_o
);

    import riscv_pkg::*;

    // jump request and target go straight through
    assign jump_flag_o = jump_flag_i;
    assign jump_addr_o = jump_addr_i;

    always_comb begin
        // jump or multiply stall freezes up to decode
        if (jump_flag_i || hold_flag_ex_i) begin
            hold_flag_o = hold_id;
        end else if (hold_flag_mems_i) begin
            // fetch only, older work keeps moving
            hold_flag_o = hold_pc;
        end else begin
            hold_flag_o = hold_none;
        end
    end

endmodule

`default_nettype wire

// File: fetch.sv
// ==============================
// program counter and the fetch/decode stage register
// pc drives the instruction memory address directly
// ==============================
`default_nettype none

module fetch (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  riscv_pkg::hold_e           hold_i,
    input  logic                       jump_flag_i,
    input  logic [riscv_pkg::xlen-1:0] jump_addr_i,
    input  logic [31:0]                inst_i,
    output logic [riscv_pkg::xlen-1:0] inst_addr_o,
    output riscv_pkg::if_id_t          if_id_o
);

    import riscv_pkg::*;

    logic [xlen-1:0] pc_q;
    if_id_t          if_id_q;

    assign inst_addr_o = pc_q;
    assign if_id_o     = if_id_q;

    // pc: redirect beats every hold
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= '0;
        end else if (jump_flag_i) begin
            pc_q <= jump_addr_i;
        end else if (hold_i == hold_none) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    // if/id register
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            if_id_q.inst <= nop_inst;
            if_id_q.pc   <= '0;
        end else if (jump_flag_i) begin
            // squash the word fetched down the wrong path
            if_id_q.inst <= nop_inst;
            if_id_q.pc   <= '0;
        end else if (hold_i == hold_id) begin
            // keep the word for decode to retry
            if_id_q <= if_id_q;
        end else if (hold_i == hold_pc) begin
            // memory not ready, nothing valid to pass on
            if_id_q.inst <= nop_inst;
            if_id_q.pc   <= '0;
        end else begin
            if_id_q.inst <= inst_i;
            if_id_q.pc   <= pc_q;
        end
    end

endmodule

`default_nettype wire

// File: regs.sv
// ==============================
// 32 x 32 register file, x0 fixed at zero
// read ports see a same-cycle write
// ==============================
`default_nettype none

module regs (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic                             we_i,
    input  logic [riscv_pkg::reg_addr_w-1:0] waddr_i,
    input  logic [riscv_pkg::xlen-1:0]       wdata_i,
    input  logic [riscv_pkg::reg_addr_w-1:0] raddr1_i,
    input  logic [riscv_pkg::reg_addr_w-1:0] raddr2_i,
    output logic [riscv_pkg::xlen-1:0]       rdata1_o,
    output logic [riscv_pkg::xlen-1:0]       rdata2_o
);

    import riscv_pkg::*;

    logic [xlen-1:0] rf_q [32];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                rf_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            rf_q[waddr_i] <= wdata_i;
        end
    end

    // write-through, so execute results reach decode without forwarding
    always_comb begin
        if (raddr1_i == '0) begin
            rdata1_o = '0;
        end else if (we_i && (waddr_i == raddr1_i)) begin
            rdata1_o = wdata_i;
        end else begin
            rdata1_o = rf_q[raddr1_i];
        end
    end

    always_comb begin
        if (raddr2_i == '0) begin
            rdata2_o = '0;
        end else if (we_i && (waddr_i == raddr2_i)) begin
            rdata2_o = wdata_i;
        end else begin
            rdata2_o = rf_q[raddr2_i];
        end
    end

endmodule

`default_nettype wire

// File: decode.sv
// ==============================
// instruction decode and operand read
// feeds the decode/execute stage register
// ==============================
`default_nettype none

module decode (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  riscv_pkg::if_id_t                if_id_i,
    input  riscv_pkg::hold_e                 hold_i,
    input  logic                             jump_flag_i,
    input  logic [riscv_pkg::xlen-1:0]       rdata1_i,
    input  logic [riscv_pkg::xlen-1:0]       rdata2_i,
    output logic [riscv_pkg::reg_addr_w-1:0] raddr1_o,
    output logic [riscv_pkg::reg_addr_w-1:0] raddr2_o,
    output riscv_pkg::id_ex_t                id_ex_o
);

    import riscv_pkg::*;

    inst_u           inst;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_j;
    id_ex_t          id_ex_d;
    id_ex_t          id_ex_q;

    assign inst = if_id_i.inst;

    // rs1 and rs2 sit in the same bits for every format used here
    assign raddr1_o = inst.r.rs1;
    assign raddr2_o = inst.r.rs2;

    // sign-extended immediates
    assign imm_i = {{20{inst.i.imm12[11]}}, inst.i.imm12};
    assign imm_b = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                    inst.b.imm10_5, inst.b.imm4_1, 1'b0};
    assign imm_j = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
                    inst.j.imm11, inst.j.imm10_1, 1'b0};

    always_comb begin
        id_ex_d         = '0;
        id_ex_d.valid   = 1'b1;
        id_ex_d.op_a    = rdata1_i;
        id_ex_d.op_b    = rdata2_i;
        id_ex_d.rs2_val = rdata2_i;
        id_ex_d.pc      = if_id_i.pc;
        id_ex_d.rd      = inst.r.rd;
        case (inst.r.opcode)
            op_op: begin
                // funct7 picks between the R-type ops
                if (inst.r.funct3 == 3'd0 && inst.r.funct7 == 7'h00) begin
                    id_ex_d.alu_op = alu_add;
                end else if (inst.r.funct3 == 3'd0 && inst.r.funct7 == 7'h20) begin
                    id_ex_d.alu_op = alu_sub;
                end else if (inst.r.funct3 == 3'd0 && inst.r.funct7 == 7'h01) begin
                    id_ex_d.alu_op = alu_mul;
                end else if (inst.r.funct3 == 3'd4 && inst.r.funct7 == 7'h00) begin
                    id_ex_d.alu_op = alu_xor;
                end else begin
                    id_ex_d.valid = 1'b0;
                end
            end
            op_imm: begin
                // only ADDI kept
                id_ex_d.alu_op = alu_add;
                id_ex_d.op_b   = imm_i;
                id_ex_d.valid  = (inst.i.funct3 == 3'd0);
            end
            op_branch: begin
                id_ex_d.imm = imm_b;
                id_ex_d.rd  = '0;
                if (inst.b.funct3 == 3'd0) begin
                    id_ex_d.alu_op = alu_beq;
                end else if (inst.b.funct3 == 3'd1) begin
                    id_ex_d.alu_op = alu_bne;
                end else begin
                    id_ex_d.valid = 1'b0;
                end
            end
            op_jal: begin
                id_ex_d.alu_op = alu_jal;
                id_ex_d.imm    = imm_j;
            end
            default: begin
                id_ex_d.valid = 1'b0;
            end
        endcase
        // no write to x0 and unknown words become bubbles
        id_ex_d.we = id_ex_d.valid && (id_ex_d.rd != '0);
        if (!id_ex_d.valid) begin
            id_ex_d = '0;
        end
    end

    // id/ex register
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_ex_q <= '0;
        end else if (jump_flag_i || (hold_i == hold_id)) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q <= id_ex_d;
        end
    end

    assign id_ex_o = id_ex_q;

endmodule

`default_nettype wire

// File: mul_unit.sv
// ==============================
// iterative shift-add multiplier, low 32 bits of the product
// one step per cycle, done pulses when the result is ready
// ==============================
`default_nettype none

module mul_unit (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       start_i,
    input  logic [riscv_pkg::xlen-1:0] a_i,
    input  logic [riscv_pkg::xlen-1:0] b_i,
    output logic                       busy_o,
    output logic                       done_o,
    output logic [riscv_pkg::xlen-1:0] product_o
);

    import riscv_pkg::*;

    logic            busy_q;
    logic            done_q;
    logic [4:0]      cnt_q;
    logic [xlen-1:0] acc_q;
    logic [xlen-1:0] mcand_q;
    logic [xlen-1:0] mplier_q;

    // step counter, 32 steps after start
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 5'd1;
                if (cnt_q == 5'd31) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // data path
    always_ff @(posedge clk) begin
        if (start_i) begin
            acc_q    <= '0;
            mcand_q  <= a_i;
            mplier_q <= b_i;
        end else if (busy_q) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;
            end
            // bits shifted past 31 are dropped
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign busy_o    = busy_q;
    assign done_o    = done_q;
    assign product_o = acc_q;

endmodule

`default_nettype wire

// File: ex.sv
// ==============================
// execute stage, ALU, branch resolution and register writeback
// raises a stall while the multiplier runs
// ==============================
`default_nettype none

module ex (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  riscv_pkg::id_ex_t                id_ex_i,
    output logic                             we_o,
    output logic [riscv_pkg::reg_addr_w-1:0] rd_o,
    output logic [riscv_pkg::xlen-1:0]       wdata_o,
    output logic                             jump_flag_o,
    output logic [riscv_pkg::xlen-1:0]       jump_addr_o,
    output logic                             hold_flag_o
);

    import riscv_pkg::*;

    logic                  is_mul;
    logic                  mul_busy;
    logic                  mul_done;
    logic [xlen-1:0]       mul_product;
    logic [reg_addr_w-1:0] mul_rd_q;

    assign is_mul = id_ex_i.valid && (id_ex_i.alu_op == alu_mul);

    mul_unit u_mul (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .start_i   (is_mul),
        .a_i       (id_ex_i.op_a),
        .b_i       (id_ex_i.op_b),
        .busy_o    (mul_busy),
        .done_o    (mul_done),
        .product_o (mul_product)
    );

    // stage register turns into a bubble during the stall, keep rd here
    always_ff @(posedge clk) begin
        if (is_mul) begin
            mul_rd_q <= id_ex_i.rd;
        end
    end

    // stall from the start cycle until done
    assign hold_flag_o = is_mul || mul_busy;

    always_comb begin
        we_o        = 1'b0;
        rd_o        = id_ex_i.rd;
        wdata_o     = '0;
        jump_flag_o = 1'b0;
        // branch and JAL share the target adder
        jump_addr_o = id_ex_i.pc + id_ex_i.imm;
        if (mul_done) begin
            // execute holds a bubble in this cycle
            we_o    = (mul_rd_q != '0);
            rd_o    = mul_rd_q;
            wdata_o = mul_product;
        end else if (id_ex_i.valid) begin
            case (id_ex_i.alu_op)
                alu_add: begin
                    we_o    = id_ex_i.we;
                    wdata_o = id_ex_i.op_a + id_ex_i.op_b;
                end
                alu_sub: begin
                    we_o    = id_ex_i.we;
                    wdata_o = id_ex_i.op_a - id_ex_i.op_b;
                end
                alu_xor: begin
                    we_o    = id_ex_i.we;
                    wdata_o = id_ex_i.op_a ^ id_ex_i.op_b;
                end
                alu_beq: begin
                    jump_flag_o = (id_ex_i.op_a == id_ex_i.rs2_val);
                end
                alu_bne: begin
                    jump_flag_o = (id_ex_i.op_a != id_ex_i.rs2_val);
                end
                alu_jal: begin
                    // link value is the next sequential pc
                    we_o        = id_ex_i.we;
                    wdata_o     = id_ex_i.pc + 32'd4;
                    jump_flag_o = 1'b1;
                end
                default: begin
                    // mul writes back later from the multiplier
                    we_o = 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: core_top.sv
// ==============================
// top of the three-stage RV32 core
// instruction memory outside, register writes visible on wb ports
// ==============================
`default_nettype none

module core_top (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic [31:0]                      inst_i,
    input  logic                             inst_wait_i,
    output logic [riscv_pkg::xlen-1:0]       inst_addr_o,
    output logic                             wb_we_o,
    output logic [riscv_pkg::reg_addr_w-1:0] wb_rd_o,
    output logic [riscv_pkg::xlen-1:0]       wb_data_o
);

    import riscv_pkg::*;

    hold_e                 hold;
    logic                  ex_jump_flag;
    logic [xlen-1:0]       ex_jump_addr;
    logic                  ex_hold_flag;
    logic                  jump_flag;
    logic [xlen-1:0]       jump_addr;
    if_id_t                if_id;
    id_ex_t                id_ex;
    logic [reg_addr_w-1:0] raddr1;
    logic [reg_addr_w-1:0] raddr2;
    logic [xlen-1:0]       rdata1;
    logic [xlen-1:0]       rdata2;

    ctrl u_ctrl (
        .jump_flag_i      (ex_jump_flag),
        .jump_addr_i      (ex_jump_addr),
        .hold_flag_ex_i   (ex_hold_flag),
        // memory wait is the only fetch-side stall
        .hold_flag_mems_i (inst_wait_i),
        .hold_flag_o      (hold),
        .jump_flag_o      (jump_flag),
        .jump_addr_o      (jump_addr)
    );

    fetch u_fetch (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .hold_i      (hold),
        .jump_flag_i (jump_flag),
        .jump_addr_i (jump_addr),
        .inst_i      (inst_i),
        .inst_addr_o (inst_addr_o),
        .if_id_o     (if_id)
    );

    // write port shared with the writeback outputs
    regs u_regs (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .we_i     (wb_we_o),
        .waddr_i  (wb_rd_o),
        .wdata_i  (wb_data_o),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    decode u_decode (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .if_id_i     (if_id),
        .hold_i      (hold),
        .jump_flag_i (jump_flag),
        .rdata1_i    (rdata1),
        .rdata2_i    (rdata2),
        .raddr1_o    (raddr1),
        .raddr2_o    (raddr2),
        .id_ex_o     (id_ex)
    );

    ex u_ex (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .id_ex_i     (id_ex),
        .we_o        (wb_we_o),
        .rd_o        (wb_rd_o),
        .wdata_o     (wb_data_o),
        .jump_flag_o (ex_jump_flag),
        .jump_addr_o (ex_jump_addr),
        .hold_flag_o (ex_hold_flag)
    );

endmodule

`default_nettype wire

// File: tb_core.sv
// ==============================
// testbench for the RV32 core with random programs against an ISA model
// each writeback is compared in program order
// ==============================
`default_nettype none

module tb_core;

    typedef enum int {k_add, k_sub, k_xor, k_addi, k_beq, k_bne, k_jal, k_mul} kind_e;

    logic        clk;
    logic        rst_n;
    logic [31:0] inst;
    logic        inst_wait;
    logic [31:0] inst_addr;
    logic        wb_we;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    // program under test with the self-loop in the last slot
    kind_e       prog_kind [64];
    logic [4:0]  prog_rd   [64];
    logic [4:0]  prog_rs1  [64];
    logic [4:0]  prog_rs2  [64];
    int          prog_imm  [64];
    int          prog_len;
    logic [31:0] rom       [256];

    // expected writes from the model
    logic [4:0]  exp_rd   [$];
    logic [31:0] exp_data [$];

    int seed;
    int checks;
    int errors;
    int checked;
    int tests_passed;
    int watch_cycles;
    int prog_lens [6];

    core_top dut (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .inst_i      (inst),
        .inst_wait_i (inst_wait),
        .inst_addr_o (inst_addr),
        .wb_we_o     (wb_we),
        .wb_rd_o     (wb_rd),
        .wb_data_o   (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // instruction memory answers in the same cycle
    always_comb begin
        if (inst_addr[31:10] == '0) begin
            inst = rom[inst_addr[9:2]];
        end else begin
            inst = enc_j(21'd0, 5'd0);
        end
    end

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    // RV32 encoders
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [4:0] rd);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] encode_word(input int i);
        logic [31:0] w;
        case (prog_kind[i])
            k_add:   w = enc_r(7'h00, prog_rs2[i], prog_rs1[i], 3'd0, prog_rd[i]);
            k_sub:   w = enc_r(7'h20, prog_rs2[i], prog_rs1[i], 3'd0, prog_rd[i]);
            k_xor:   w = enc_r(7'h00, prog_rs2[i], prog_rs1[i], 3'd4, prog_rd[i]);
            k_mul:   w = enc_r(7'h01, prog_rs2[i], prog_rs1[i], 3'd0, prog_rd[i]);
            k_addi:  w = enc_i(12'(prog_imm[i]), prog_rs1[i], prog_rd[i]);
            k_beq:   w = enc_b(13'(prog_imm[i]), prog_rs2[i], prog_rs1[i], 3'd0);
            k_bne:   w = enc_b(13'(prog_imm[i]), prog_rs2[i], prog_rs1[i], 3'd1);
            k_jal:   w = enc_j(21'(prog_imm[i]), prog_rd[i]);
            default: w = enc_j(21'd0, 5'd0);
        endcase
        return w;
    endfunction

    // mix 0 is alu only, 1 adds control flow, 2 is mul heavy and 3 has everything
    task automatic build_program(input int len, input int mix);
        int bound;
        int pick;
        prog_len = len;
        for (int i = 0; i < len - 1; i++) begin
            prog_rd[i]  = 5'(rand_below(8));
            prog_rs1[i] = 5'(rand_below(8));
            prog_rs2[i] = 5'(rand_below(8));
            prog_imm[i] = rand_below(4096) - 2048;
            if (i < 4) begin
                // seed x1..x4 so operands are not all zero
                prog_kind[i] = k_addi;
                prog_rd[i]   = 5'(i + 1);
                prog_rs1[i]  = 5'd0;
            end else begin
                pick = rand_below(8);
                case (mix)
                    0: pick = pick % 4;
                    1: pick = pick % 7;
                    2: begin
                        if (pick >= 4) begin
                            pick = int'(k_mul);
                        end
                    end
                    default: ;
                endcase
                prog_kind[i] = kind_e'(pick);
            end
            if (prog_kind[i] inside {k_beq, k_bne, k_jal}) begin
                // forward only and never past the self-loop
                bound = len - 1 - i;
                if (bound > 4) begin
                    bound = 4;
                end
                prog_imm[i] = 4 * (1 + rand_below(bound));
                // equal operands half the time so branches get taken
                if (rand_below(2) == 0) begin
                    prog_rs2[i] = prog_rs1[i];
                end
            end
            // consumer right behind a mul
            if (mix == 2 && i > 4 && prog_kind[i-1] == k_mul && prog_kind[i] != k_jal) begin
                prog_rs1[i] = prog_rd[i-1];
            end
        end
        prog_kind[len-1] = k_jal;
        prog_rd[len-1]   = 5'd0;
        prog_imm[len-1]  = 0;
    endtask

    // instruction-set model walking the program in order
    task automatic run_model();
        logic [31:0] mregs [32];
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] val;
        logic        wr;
        int          pc_idx;
        int          next;
        for (int r = 0; r < 32; r++) begin
            mregs[r] = '0;
        end
        exp_rd.delete();
        exp_data.delete();
        pc_idx = 0;
        while (pc_idx < prog_len - 1) begin
            a    = mregs[prog_rs1[pc_idx]];
            b    = mregs[prog_rs2[pc_idx]];
            wr   = 1'b1;
            val  = '0;
            next = pc_idx + 1;
            case (prog_kind[pc_idx])
                k_add:  val = a + b;
                k_sub:  val = a - b;
                k_xor:  val = a ^ b;
                k_mul:  val = a * b;
                k_addi: val = a + 32'(prog_imm[pc_idx]);
                k_beq: begin
                    wr = 1'b0;
                    if (a == b) begin
                        next = pc_idx + prog_imm[pc_idx] / 4;
                    end
                end
                k_bne: begin
                    wr = 1'b0;
                    if (a != b) begin
                        next = pc_idx + prog_imm[pc_idx] / 4;
                    end
                end
                k_jal: begin
                    val  = 32'(pc_idx * 4 + 4);
                    next = pc_idx + prog_imm[pc_idx] / 4;
                end
                default: wr = 1'b0;
            endcase
            if (wr && prog_rd[pc_idx] != 5'd0) begin
                mregs[prog_rd[pc_idx]] = val;
                exp_rd.push_back(prog_rd[pc_idx]);
                exp_data.push_back(val);
            end
            pc_idx = next;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got 0x%08h expected 0x%08h",
                     $time, name, got, exp);
        end
    endtask

    // reset held for 4 cycles while the new program goes into the ROM
    task automatic start_program(input int len, input int mix);
        @(posedge clk);
        #1;
        rst_n     = 1'b0;
        inst_wait = 1'b0;
        build_program(len, mix);
        run_model();
        for (int i = 0; i < 256; i++) begin
            rom[i] = enc_j(21'd0, 5'd0);
        end
        for (int i = 0; i < len; i++) begin
            rom[i] = encode_word(i);
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // fetch starts at address zero out of reset
        check_value("inst_addr_o", inst_addr, 32'd0);
    endtask

    // stop_after below zero runs until the model list is used up plus 40 quiet cycles
    task automatic run_program(input int wait_pct, input int stop_after);
        int idle;
        bit finished;
        idle     = 0;
        finished = 1'b0;
        checked  = 0;
        while (!finished) begin
            @(negedge clk);
            if (wb_we) begin
                idle = 0;
                if (wb_rd == 5'd0) begin
                    errors++;
                    $display("ERROR at %0t: a write to x0 appeared on the writeback port",
                             $time);
                end
                if (checked < exp_rd.size()) begin
                    check_value("wb_rd_o", 32'(wb_rd), 32'(exp_rd[checked]));
                    check_value("wb_data_o", wb_data, exp_data[checked]);
                    checked++;
                end else begin
                    errors++;
                    $display("ERROR at %0t: extra register write x%0d = 0x%08h",
                             $time, wb_rd, wb_data);
                end
            end else begin
                idle++;
            end
            if (stop_after >= 0 && checked >= stop_after) begin
                finished = 1'b1;
            end else if (checked >= exp_rd.size() && idle >= 40) begin
                finished = 1'b1;
            end
            @(posedge clk);
            #1;
            inst_wait = (wait_pct > 0) && (rand_below(100) < wait_pct);
        end
    endtask

    task automatic report_test(input int id, input string name, input int err_start);
        if (errors == err_start) begin
            tests_passed++;
        end
        $display("test %0d %s: %s, %0d of %0d writes checked", id, name,
                 (errors == err_start) ? "pass" : "FAIL", checked, exp_rd.size());
    endtask

    task automatic run_test(input int id, input string name, input int len,
                            input int mix, input int wait_pct);
        int err_start;
        err_start = errors;
        start_program(len, mix);
        run_program(wait_pct, -1);
        report_test(id, name, err_start);
    endtask

    task automatic reset_midway_test(input int id, input int len_a, input int len_b);
        int err_start;
        err_start = errors;
        start_program(len_a, 3);
        // a few writes of the first program before reset cuts it off
        run_program(30, 3);
        start_program(len_b, 3);
        run_program(0, -1);
        report_test(id, "reset", err_start);
    endtask

    initial begin : watchdog
        wait (watch_cycles > 0);
        repeat (watch_cycles) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles, the core stopped making progress",
                 watch_cycles);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        rst_n        = 1'b0;
        inst_wait    = 1'b0;
        seed         = 22;
        checks       = 0;
        errors       = 0;
        checked      = 0;
        tests_passed = 0;
        watch_cycles = 0;
        for (int i = 0; i < 256; i++) begin
            rom[i] = enc_j(21'd0, 5'd0);
        end
        // lengths first so the watchdog limit is known up front
        for (int t = 0; t < 6; t++) begin
            prog_lens[t] = 20 + rand_below(16);
            watch_cycles = watch_cycles + prog_lens[t] * 50;
        end
        run_test(1, "alu", prog_lens[0], 0, 0);
        run_test(2, "branch", prog_lens[1], 1, 0);
        run_test(3, "mul", prog_lens[2], 2, 0);
        run_test(4, "wait", prog_lens[3], 3, 30);
        reset_midway_test(5, prog_lens[4], prog_lens[5]);
        $display("%0d of 5 tests passed, %0d checks, %0d errors",
                 tests_passed, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
riscv_pkg.sv
ctrl.sv
fetch.sv
regs.sv
decode.sv
mul_unit.sv
ex.sv
core_top.sv
tb_core.sv

// File: run.sh
#!/bin/sh
# build the core testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f verilog.f --top-module tb_core -o tb_core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
    exit 0
fi
exit 1
